// ==== verilog.f ====
logic/chess_pkg.sv
logic/regmap_pkg.sv
logic/axi_lite_ctrl.sv
logic/setup_regs.sv
logic/board_regs.sv
logic/read_mux.sv
logic/move_gen_host.sv
tb/axi_lite_assert.sv
tb/tb_move_gen_host.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the move_gen_host testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_move_gen_host -Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_move_gen_host" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb/tb_move_gen_host.sv ====
module tb_move_gen_host;
   timeunit 1ns;
   timeprecision 1ps;
   import chess_pkg::*;
   import regmap_pkg::*;

   localparam int ROUNDS         = 6;
   localparam int MOVE_ROUNDS    = 3;
   localparam int TRANSACTIONS   = 5 + ROUNDS * 10 + 16 + ROUNDS * 3 + MOVE_ROUNDS * 17 + 38 + 8;
   localparam int TIMEOUT_CYCLES = 40 * TRANSACTIONS + 20;   // Margin for reset

   logic         clk;
   logic         rst_n;
   axi_req_t     req;
   axi_rsp_t     rsp;
   root_status_t root_status;
   logic [31:0]  root_eval;
   logic [7:0]   move_count;
   move_result_t move_result;
   ctrl_flags_t  ctrl;
   logic [7:0]   move_index;
   position_t    position;
   logic [9:0]   half_move;
   logic         capture_moves;
   board_t       board;

   logic [31:0] shadow [16];   // Last word written per writable index
   logic [31:0] expected_q [$];
   logic [9:0]  index_q [$];
   logic [31:0] held;
   integer      seed = 32'hecca;
   int          error_count = 0;
   int          check_count = 0;
   int          test_base = 0;
   int          unmapped [10] = '{5, 6, 7, 16, 127, 137, 171, 180, 511, 1023};
   int          read_only [6] = '{128, 132, 135, 136, 172, 1023};

   move_gen_host i_move_gen_host (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .rsp           (rsp),
      .root_status   (root_status),
      .root_eval     (root_eval),
      .move_count    (move_count),
      .move_result   (move_result),
      .ctrl          (ctrl),
      .move_index    (move_index),
      .position      (position),
      .half_move     (half_move),
      .capture_moves (capture_moves),
      .board         (board)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: transactions did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
   end

   function automatic logic [31:0] expected_read(input logic [9:0] index);
      logic [31:0] word;
      word = 32'h0;
      case (index) inside
         10'd0: word = (shadow[0] & 32'hc000_0003) | {22'h0, root_status.insufficient_material,
                   root_status.fifty_move, root_status.idle, root_status.thrice_rep,
                   root_status.mate, root_status.stalemate, root_status.move_ready,
                   root_status.moves_ready, 2'b00};
         10'd1: word = shadow[1] & 32'h0000_00ff;
         10'd2: word = shadow[2] & 32'h0000_01ff;
         10'd3: word = shadow[3] & 32'h0000_03ff;
         10'd4: word = shadow[4] & 32'h0000_0001;
         [10'd8:10'd15]: word = shadow[index[3:0]];
         10'd128: word = move_result.white_attacks[31:0];
         10'd129: word = move_result.white_attacks[63:32];
         10'd130: word = move_result.black_attacks[31:0];
         10'd131: word = move_result.black_attacks[63:32];
         10'd132: word = {26'h0, move_result.insufficient_material, move_result.fifty_move,
                          move_result.thrice_rep, move_result.black_in_check,
                          move_result.white_in_check, move_result.capture};
         10'd133: word = {23'h0, move_result.position};
         10'd134: word = move_result.eval;
         10'd135: word = {24'h0, move_count};
         10'd136: word = root_eval;
         [10'd172:10'd179]: word = move_result.board[3'(index - 10'd172)];
         default: word = 32'h0;
      endcase
      return word;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count++;
      if (got !== expected)
      begin
         $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, expected);
         error_count++;
      end
   endtask

   task automatic drive_write(input logic [9:0] index, input logic [31:0] data);
      @(posedge clk);
      req.awaddr  <= {4'h0, index, 2'b00};
      req.awvalid <= 1'b1;
      req.wdata   <= data;
      req.wvalid  <= 1'b1;
   endtask

   task automatic await_write_accept();
      do
      begin
         @(posedge clk);
         if (req.awvalid && rsp.awready)
            req.awvalid <= 1'b0;
         if (req.wvalid && rsp.wready)
            req.wvalid <= 1'b0;
      end
      while (req.awvalid || req.wvalid);
   endtask

   task automatic await_write_response();
      do
         @(posedge clk);
      while (!(rsp.bvalid && req.bready));
      check_value("bresp", 32'(rsp.bresp), 32'h0);   // OKAY
   endtask

   task automatic write_reg(input logic [9:0] index, input logic [31:0] data);
      drive_write(index, data);
      await_write_accept();
      await_write_response();
      @(posedge clk);   // Register loads with the strobe
      if (index <= 10'd4 || (index >= 10'd8 && index <= 10'd15))
         shadow[index[3:0]] = data;
   endtask

   task automatic await_read_accept(input logic [9:0] index);
      do
         @(posedge clk);
      while (!(req.arvalid && rsp.arready));
      expected_q.push_back(expected_read(index));
      index_q.push_back(index);
      req.arvalid <= 1'b0;
   endtask

   task automatic read_reg(input logic [9:0] index);
      @(posedge clk);
      req.araddr  <= {4'h0, index, 2'b00};
      req.arvalid <= 1'b1;
      await_read_accept(index);
      do
         @(posedge clk);
      while (!(rsp.rvalid && req.rready));
   endtask

   task automatic randomize_move_result();
      board_t rows;
      for (int i = 0; i < 8; i++)
         rows[3'(i)] = $random(seed);
      @(posedge clk);
      move_result.board         <= rows;
      move_result.position      <= position_t'(9'($random(seed)));
      {move_result.white_in_check, move_result.black_in_check, move_result.capture,
       move_result.thrice_rep, move_result.fifty_move,
       move_result.insufficient_material} <= 6'($random(seed));
      move_result.white_attacks <= {$random(seed), $random(seed)};
      move_result.black_attacks <= {$random(seed), $random(seed)};
      move_result.eval          <= $random(seed);
   endtask

   task automatic finish_test(input string name);
      @(posedge clk);   // Last compare retires here
      if (error_count == test_base)
         $display("PASS %s", name);
      else
         $display("FAIL %s (%0d errors)", name, error_count - test_base);
      test_base = error_count;
   endtask

   // Every completed read against the value expected at its acceptance
   always @(posedge clk)
   begin
      if (rst_n && rsp.rvalid && req.rready)
      begin
         check_count++;
         if (expected_q.size() == 0)
         begin
            $display("Read data returned with no read outstanding");
            error_count++;
         end
         else if (rsp.rdata !== expected_q[0])
         begin
            $display("MISMATCH rdata at index 0x%03h: got 0x%08h, expected 0x%08h",
                     index_q[0], rsp.rdata, expected_q[0]);
            error_count++;
         end
         if (expected_q.size() != 0)
         begin
            void'(expected_q.pop_front());
            void'(index_q.pop_front());
         end
         check_value("rresp", 32'(rsp.rresp), 32'h0);
      end
   end

   initial
   begin
      req         <= '0;
      req.bready  <= 1'b1;
      req.rready  <= 1'b1;
      root_status <= '0;
      root_eval   <= '0;
      move_count  <= '0;
      move_result <= '0;
      rst_n       <= 1'b0;
      foreach (shadow[i])
         shadow[i] = 32'h0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_count++;
      if (rsp.bvalid || rsp.rvalid || !rsp.awready || !rsp.wready || !rsp.arready)
      begin
         $display("Handshake outputs not at their reset values after reset");
         error_count++;
      end
      for (int i = 0; i <= 4; i++)
         read_reg(10'(i));
      finish_test("reset state");

      for (int r = 0; r < ROUNDS; r++)
      begin
         for (int i = 0; i <= 4; i++)
            write_reg(10'(i), $random(seed));
         check_value("ctrl", 32'({ctrl.new_board_valid, ctrl.clear_moves, ctrl.use_random_bit,
                     ctrl.soft_reset}), 32'({shadow[0][0], shadow[0][1], shadow[0][30],
                     shadow[0][31]}));
         check_value("move_index", 32'(move_index), shadow[1] & 32'h0000_00ff);
         check_value("position", 32'({position.white_to_move, position.castle_mask,
                     position.en_passant_col}), shadow[2] & 32'h0000_01ff);
         check_value("half_move", 32'(half_move), shadow[3] & 32'h0000_03ff);
         check_value("capture_moves", 32'(capture_moves), shadow[4] & 32'h0000_0001);
         for (int i = 0; i <= 4; i++)
            read_reg(10'(i));
      end
      finish_test("test 1 setup registers");

      for (int i = 0; i < 8; i++)
         write_reg(10'(8 + i), $random(seed));
      for (int i = 0; i < 8; i++)
      begin
         check_value("board row", board[3'(i)], shadow[4'(8 + i)]);
         read_reg(10'(8 + i));
      end
      finish_test("test 2 board rows");

      for (int r = 0; r < ROUNDS; r++)
      begin
         @(posedge clk);
         root_status <= root_status_t'(8'($random(seed)));
         root_eval   <= $random(seed);
         move_count  <= 8'($random(seed));
         read_reg(REG_CTRL);
         read_reg(REG_ROOT_EVAL);
         read_reg(REG_MOVE_COUNT);
      end
      finish_test("test 3 root status");

      for (int r = 0; r < MOVE_ROUNDS; r++)
      begin
         randomize_move_result();
         for (int i = 128; i <= 136; i++)
            read_reg(10'(i));
         for (int i = 172; i < 180; i++)
            read_reg(10'(i));
      end
      finish_test("test 4 indexed move");

      foreach (unmapped[i])
         read_reg(10'(unmapped[i]));
      foreach (read_only[i])
      begin
         write_reg(10'(read_only[i]), $random(seed));
         read_reg(10'(read_only[i]));
      end
      for (int i = 0; i < 16; i++)
         read_reg(10'(i));
      finish_test("test 5 unmapped and read-only");

      @(posedge clk);
      req.bready <= 1'b0;
      drive_write(REG_MOVE_INDEX, 32'h0000_005a);
      await_write_accept();
      do
         @(posedge clk);
      while (!rsp.bvalid);
      drive_write(REG_HALF_MOVE, 32'h0000_02c3);
      repeat (6)
      begin
         @(posedge clk);
         check_count++;
         if (!rsp.bvalid || rsp.awready || rsp.wready)
         begin
            $display("Second write accepted or bvalid dropped while bready was low");
            error_count++;
         end
      end
      req.bready <= 1'b1;
      await_write_response();
      await_write_accept();
      await_write_response();
      @(posedge clk);
      shadow[1] = 32'h0000_005a;
      shadow[3] = 32'h0000_02c3;
      read_reg(REG_MOVE_INDEX);
      read_reg(REG_HALF_MOVE);

      @(posedge clk);
      req.rready  <= 1'b0;
      req.araddr  <= {4'h0, REG_ROOT_EVAL, 2'b00};
      req.arvalid <= 1'b1;
      await_read_accept(REG_ROOT_EVAL);
      do
         @(posedge clk);
      while (!rsp.rvalid);
      held = expected_read(REG_ROOT_EVAL);
      root_eval   <= ~root_eval;   // New value must not reach held rdata
      req.arvalid <= 1'b1;
      repeat (6)
      begin
         @(posedge clk);
         check_value("rdata while rready low", rsp.rdata, held);
         check_count++;
         if (!rsp.rvalid || rsp.arready)
         begin
            $display("Next read accepted or rvalid dropped while rready was low");
            error_count++;
         end
      end
      req.rready <= 1'b1;
      await_read_accept(REG_ROOT_EVAL);
      do
         @(posedge clk);
      while (!(rsp.rvalid && req.rready));
      finish_test("test 6 back-pressure");

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// ==== tb/axi_lite_assert.sv ====
module axi_lite_assert (
   input logic                 clk,
   input logic                 rst_n,
   input regmap_pkg::axi_req_t req,
   input regmap_pkg::axi_rsp_t rsp,
   input regmap_pkg::wr_cmd_t  wr_cmd
);
   timeunit 1ns;
   timeprecision 1ps;

   bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.bvalid && !req.bready |=> rsp.bvalid)
      else $error("bvalid dropped before bready was seen");

   rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
      else $error("rdata or rvalid changed while waiting for rready");

   strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
      wr_cmd.strobe |=> !wr_cmd.strobe)
      else $error("write strobe held longer than one cycle");

   // Write channels stay closed while a response is pending
   write_closed: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.bvalid |-> !rsp.awready && !rsp.wready)
      else $error("awready or wready high while bvalid is high");

endmodule

bind axi_lite_ctrl axi_lite_assert i_axi_lite_assert (
   .clk    (clk),
   .rst_n  (rst_n),
   .req    (req),
   .rsp    (rsp),
   .wr_cmd (wr_cmd)
);

// ==== logic/move_gen_host.sv ====
module move_gen_host #(
   parameter int MOVE_INDEX_WIDTH = 8,
   parameter int HALF_MOVE_WIDTH  = 10
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  regmap_pkg::axi_req_t        req,
   output regmap_pkg::axi_rsp_t        rsp,
   input  chess_pkg::root_status_t     root_status,
   input  logic [31:0]                 root_eval,
   input  logic [MOVE_INDEX_WIDTH-1:0] move_count,
   input  chess_pkg::move_result_t     move_result,
   output chess_pkg::ctrl_flags_t      ctrl,
   output logic [MOVE_INDEX_WIDTH-1:0] move_index,
   output chess_pkg::position_t        position,
   output logic [HALF_MOVE_WIDTH-1:0]  half_move,
   output logic                        capture_moves,
   output chess_pkg::board_t           board
);
   import regmap_pkg::*;

   wr_cmd_t                    wr_cmd;
   logic [REG_INDEX_WIDTH-1:0] rd_index;
   logic [DATA_WIDTH-1:0]      rd_word;

   axi_lite_ctrl i_axi_lite_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .rd_word  (rd_word),
      .rsp      (rsp),
      .wr_cmd   (wr_cmd),
      .rd_index (rd_index)
   );

   setup_regs #(
      .MOVE_INDEX_WIDTH (MOVE_INDEX_WIDTH),
      .HALF_MOVE_WIDTH  (HALF_MOVE_WIDTH)
   ) i_setup_regs (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_cmd        (wr_cmd),
      .ctrl          (ctrl),
      .move_index    (move_index),
      .position      (position),
      .half_move     (half_move),
      .capture_moves (capture_moves)
   );

   board_regs i_board_regs (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr_cmd (wr_cmd),
      .board  (board)
   );

   read_mux #(
      .MOVE_INDEX_WIDTH (MOVE_INDEX_WIDTH),
      .HALF_MOVE_WIDTH  (HALF_MOVE_WIDTH)
   ) i_read_mux (
      .rd_index      (rd_index),
      .ctrl          (ctrl),
      .move_index    (move_index),
      .position      (position),
      .half_move     (half_move),
      .capture_moves (capture_moves),
      .board         (board),
      .root_status   (root_status),
      .root_eval     (root_eval),
      .move_count    (move_count),
      .move_result   (move_result),
      .rd_word       (rd_word)
   );

endmodule

// ==== logic/read_mux.sv ====
module read_mux #(
   parameter int MOVE_INDEX_WIDTH = 8,
   parameter int HALF_MOVE_WIDTH  = 10
) (
   input  logic [regmap_pkg::REG_INDEX_WIDTH-1:0] rd_index,
   input  chess_pkg::ctrl_flags_t                 ctrl,
   input  logic [MOVE_INDEX_WIDTH-1:0]            move_index,
   input  chess_pkg::position_t                   position,
   input  logic [HALF_MOVE_WIDTH-1:0]             half_move,
   input  logic                                   capture_moves,
   input  chess_pkg::board_t                      board,
   input  chess_pkg::root_status_t                root_status,
   input  logic [31:0]                            root_eval,
   input  logic [MOVE_INDEX_WIDTH-1:0]            move_count,
   input  chess_pkg::move_result_t                move_result,
   output logic [regmap_pkg::DATA_WIDTH-1:0]      rd_word
);
   import chess_pkg::*;
   import regmap_pkg::*;

   ctrl_word_t                 ctrl_word;
   logic [REG_INDEX_WIDTH-1:0] board_offset;
   logic [REG_INDEX_WIDTH-1:0] move_board_offset;

   assign board_offset      = rd_index - REG_BOARD_BASE;
   assign move_board_offset = rd_index - REG_MOVE_BOARD_BASE;

   // Written flags merged with live root status
   always_comb
   begin
      ctrl_word                       = '0;
      ctrl_word.new_board_valid       = ctrl.new_board_valid;
      ctrl_word.clear_moves           = ctrl.clear_moves;
      ctrl_word.use_random_bit        = ctrl.use_random_bit;
      ctrl_word.soft_reset            = ctrl.soft_reset;
      ctrl_word.moves_ready           = root_status.moves_ready;
      ctrl_word.move_ready            = root_status.move_ready;
      ctrl_word.stalemate             = root_status.stalemate;
      ctrl_word.mate                  = root_status.mate;
      ctrl_word.thrice_rep            = root_status.thrice_rep;
      ctrl_word.idle                  = root_status.idle;
      ctrl_word.fifty_move            = root_status.fifty_move;
      ctrl_word.insufficient_material = root_status.insufficient_material;
   end

   always_comb
   begin
      rd_word = '0;
      case (rd_index)
         REG_CTRL:          rd_word = ctrl_word;
         REG_MOVE_INDEX:    rd_word = 32'(move_index);
         REG_POSITION:      rd_word = 32'(position);
         REG_HALF_MOVE:     rd_word = 32'(half_move);
         REG_CAPTURE:       rd_word = 32'(capture_moves);
         REG_WHITE_ATK_LO:  rd_word = move_result.white_attacks[31:0];
         REG_WHITE_ATK_HI:  rd_word = move_result.white_attacks[63:32];
         REG_BLACK_ATK_LO:  rd_word = move_result.black_attacks[31:0];
         REG_BLACK_ATK_HI:  rd_word = move_result.black_attacks[63:32];
         REG_MOVE_FLAGS:
         begin
            rd_word = 32'({move_result.insufficient_material, move_result.fifty_move,
                           move_result.thrice_rep, move_result.black_in_check,
                           move_result.white_in_check, move_result.capture});
         end
         REG_MOVE_POSITION: rd_word = 32'(move_result.position);
         REG_MOVE_EVAL:     rd_word = move_result.eval;
         REG_MOVE_COUNT:    rd_word = 32'(move_count);
         REG_ROOT_EVAL:     rd_word = root_eval;
         default:
         begin
            if (board_offset < REG_INDEX_WIDTH'(BOARD_ROWS))
               rd_word = board[board_offset[ROW_SEL_WIDTH-1:0]];   // Loaded board
            else if (move_board_offset < REG_INDEX_WIDTH'(BOARD_ROWS))
               rd_word = move_result.board[move_board_offset[ROW_SEL_WIDTH-1:0]];
         end
      endcase
   end

endmodule

// ==== logic/board_regs.sv ====
module board_regs (
   input  logic                clk,
   input  logic                rst_n,
   input  regmap_pkg::wr_cmd_t wr_cmd,
   output chess_pkg::board_t   board
);
   import chess_pkg::*;
   import regmap_pkg::*;

   logic [REG_INDEX_WIDTH-1:0] row_offset;
   logic                       row_hit;

   assign row_offset = wr_cmd.index - REG_BOARD_BASE;
   assign row_hit    = row_offset < REG_INDEX_WIDTH'(BOARD_ROWS);   // Wraps below base

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         board <= '0;
      end
      else if (wr_cmd.strobe && row_hit)
      begin
         board[row_offset[ROW_SEL_WIDTH-1:0]] <= wr_cmd.data[SIDE_WIDTH-1:0];
      end
   end

endmodule

// ==== logic/setup_regs.sv ====
module setup_regs #(
   parameter int MOVE_INDEX_WIDTH = 8,
   parameter int HALF_MOVE_WIDTH  = 10
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  regmap_pkg::wr_cmd_t         wr_cmd,
   output chess_pkg::ctrl_flags_t      ctrl,
   output logic [MOVE_INDEX_WIDTH-1:0] move_index,
   output chess_pkg::position_t        position,
   output logic [HALF_MOVE_WIDTH-1:0]  half_move,
   output logic                        capture_moves
);
   import regmap_pkg::*;

   reg_word_u word;

   assign word = wr_cmd.data;   // Flags at REG_CTRL, position at REG_POSITION

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ctrl          <= '0;
         move_index    <= '0;
         position      <= '0;
         half_move     <= '0;
         capture_moves <= 1'b0;
      end
      else if (wr_cmd.strobe)
      begin
         case (wr_cmd.index)
            REG_CTRL:
            begin
               // Levels, held until rewritten
               ctrl <= '{new_board_valid: word.ctrl.new_board_valid,
                         clear_moves:     word.ctrl.clear_moves,
                         use_random_bit:  word.ctrl.use_random_bit,
                         soft_reset:      word.ctrl.soft_reset};
            end
            REG_MOVE_INDEX:
            begin
               move_index <= wr_cmd.data[MOVE_INDEX_WIDTH-1:0];
            end
            REG_POSITION:
            begin
               position <= word.pos.position;
            end
            REG_HALF_MOVE:
            begin
               half_move <= wr_cmd.data[HALF_MOVE_WIDTH-1:0];
            end
            REG_CAPTURE:
            begin
               capture_moves <= wr_cmd.data[0];
            end
            default:
            begin
               // Read-only or unmapped index
            end
         endcase
      end
   end

endmodule

// ==== logic/axi_lite_ctrl.sv ====
module axi_lite_ctrl (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  regmap_pkg::axi_req_t                   req,
   input  logic [regmap_pkg::DATA_WIDTH-1:0]      rd_word,
   output regmap_pkg::axi_rsp_t                   rsp,
   output regmap_pkg::wr_cmd_t                    wr_cmd,
   output logic [regmap_pkg::REG_INDEX_WIDTH-1:0] rd_index
);
   import regmap_pkg::*;

   logic                       aw_pending;
   logic                       w_pending;
   logic                       bvalid;
   logic                       rvalid;
   logic                       strobe;
   logic [REG_INDEX_WIDTH-1:0] aw_index;
   logic [DATA_WIDTH-1:0]      w_data;
   logic [DATA_WIDTH-1:0]      rdata;
   logic                       awready;
   logic                       wready;
   logic                       arready;
   logic                       aw_accept;
   logic                       w_accept;
   logic                       ar_accept;
   logic                       wr_fire;

   function automatic logic [REG_INDEX_WIDTH-1:0] reg_index(input logic [ADDR_WIDTH-1:0] addr);
      return addr[REG_INDEX_WIDTH+1:2];   // Word address
   endfunction

   assign awready   = !aw_pending && !bvalid;
   assign wready    = !w_pending && !bvalid;
   assign arready   = !rvalid || req.rready;   // Free once current data is taken
   assign aw_accept = req.awvalid && awready;
   assign w_accept  = req.wvalid && wready;
   assign ar_accept = req.arvalid && arready;
   assign wr_fire   = aw_pending && w_pending;
   assign rd_index  = reg_index(req.araddr);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         aw_pending <= 1'b0;
         w_pending  <= 1'b0;
         bvalid     <= 1'b0;
         rvalid     <= 1'b0;
         strobe     <= 1'b0;
      end
      else
      begin
         strobe <= wr_fire;   // One cycle, paired with bvalid
         if (wr_fire)
         begin
            aw_pending <= 1'b0;
            w_pending  <= 1'b0;
         end
         else
         begin
            if (aw_accept)
               aw_pending <= 1'b1;
            if (w_accept)
               w_pending <= 1'b1;
         end
         if (wr_fire)
            bvalid <= 1'b1;
         else if (bvalid && req.bready)
            bvalid <= 1'b0;
         if (ar_accept)
            rvalid <= 1'b1;
         else if (req.rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_accept)
         aw_index <= reg_index(req.awaddr);
      if (w_accept)
         w_data <= req.wdata;
      if (ar_accept)
         rdata <= rd_word;
   end

   assign rsp = '{awready: awready, wready: wready, bvalid: bvalid, bresp: RESP_OKAY,
                  arready: arready, rvalid: rvalid, rdata: rdata, rresp: RESP_OKAY};

   assign wr_cmd = '{strobe: strobe, index: aw_index, data: w_data};

endmodule

// ==== logic/regmap_pkg.sv ====
package regmap_pkg;

   localparam int ADDR_WIDTH      = 16;
   localparam int DATA_WIDTH      = 32;
   localparam int REG_INDEX_WIDTH = 10;   // Byte address bits 11:2

   localparam logic [1:0] RESP_OKAY = 2'b00;

   localparam logic [REG_INDEX_WIDTH-1:0] REG_CTRL            = 10'd0;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_INDEX      = 10'd1;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_POSITION        = 10'd2;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_HALF_MOVE       = 10'd3;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_CAPTURE         = 10'd4;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_BOARD_BASE      = 10'd8;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_WHITE_ATK_LO    = 10'd128;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_WHITE_ATK_HI    = 10'd129;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_BLACK_ATK_LO    = 10'd130;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_BLACK_ATK_HI    = 10'd131;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_FLAGS      = 10'd132;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_POSITION   = 10'd133;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_EVAL       = 10'd134;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_COUNT      = 10'd135;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_ROOT_EVAL       = 10'd136;
   localparam logic [REG_INDEX_WIDTH-1:0] REG_MOVE_BOARD_BASE = 10'd172;

   typedef struct packed {
      logic [ADDR_WIDTH-1:0] awaddr;
      logic                  awvalid;
      logic [DATA_WIDTH-1:0] wdata;
      logic                  wvalid;
      logic                  bready;
      logic [ADDR_WIDTH-1:0] araddr;
      logic                  arvalid;
      logic                  rready;
   } axi_req_t;

   typedef struct packed {
      logic                  awready;
      logic                  wready;
      logic                  bvalid;
      logic [1:0]            bresp;
      logic                  arready;
      logic                  rvalid;
      logic [DATA_WIDTH-1:0] rdata;
      logic [1:0]            rresp;
   } axi_rsp_t;

   typedef struct packed {
      logic                       strobe;
      logic [REG_INDEX_WIDTH-1:0] index;
      logic [DATA_WIDTH-1:0]      data;
   } wr_cmd_t;

   // Control word layout, bit 31 first
   typedef struct packed {
      logic        soft_reset;
      logic        use_random_bit;
      logic [19:0] reserved;
      logic        insufficient_material;
      logic        fifty_move;
      logic        idle;
      logic        thrice_rep;
      logic        mate;
      logic        stalemate;
      logic        move_ready;
      logic        moves_ready;
      logic        clear_moves;
      logic        new_board_valid;
   } ctrl_word_t;

   typedef struct packed {
      logic [22:0]          reserved;
      chess_pkg::position_t position;
   } pos_word_t;

   typedef union packed {
      ctrl_word_t ctrl;
      pos_word_t  pos;
   } reg_word_u;

endpackage

// ==== logic/chess_pkg.sv ====
package chess_pkg;

   localparam int PIECE_WIDTH   = 4;
   localparam int BOARD_ROWS    = 8;
   localparam int SIDE_WIDTH    = BOARD_ROWS * PIECE_WIDTH; // Eight squares per row
   localparam int ROW_SEL_WIDTH = $clog2(BOARD_ROWS);

   // Row n at bits n*SIDE_WIDTH upward
   typedef logic [BOARD_ROWS-1:0][SIDE_WIDTH-1:0] board_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   typedef struct packed {
      logic mate;
      logic stalemate;
      logic thrice_rep;
      logic fifty_move;
      logic insufficient_material;
      logic idle;
      logic moves_ready;   // All moves generated
      logic move_ready;    // Indexed move valid
   } root_status_t;

   typedef struct packed {
      board_t      board;
      position_t   position;
      logic        white_in_check;
      logic        black_in_check;
      logic        capture;
      logic        thrice_rep;
      logic        fifty_move;
      logic        insufficient_material;
      logic [63:0] white_attacks;   // One bit per square
      logic [63:0] black_attacks;
      logic [31:0] eval;            // Sign-extended
   } move_result_t;

   typedef struct packed {
      logic new_board_valid;
      logic clear_moves;
      logic use_random_bit;
      logic soft_reset;
   } ctrl_flags_t;

endpackage
